//--- rtl/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int COUNT_W   = 32;
    localparam int OPCODE_W  = 6;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [COUNT_W-1:0]   count_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;

    // primary opcode field, inst[31:26]
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;
    localparam logic [2:0] OP_IMM_GRP = 3'b001; // addi .. lui share the top bits

    localparam opcode_t FUNCT_JR = 6'h08; // funct field under SPECIAL

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd31; // jal link

    typedef struct packed {
        logic  ok1;
        addr_t addr1;
        word_t inst1;
        logic  ok2;
        addr_t addr2;
        word_t inst2;
    } fetch_pair_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t inst;
    } slot_t;

    typedef struct packed {
        logic     writes_reg;
        reg_idx_t dst;
        reg_idx_t src_a;
        reg_idx_t src_b;
        logic     is_branch;
        logic     is_mem;
    } dec_info_t;

    typedef struct packed {
        slot_t master;
        slot_t slave;
        logic  master_in_delay_slot;
    } issue_t;

endpackage

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  frontend_pkg::slot_t     slot,
    output frontend_pkg::dec_info_t info
);

    frontend_pkg::opcode_t  op;
    frontend_pkg::opcode_t  funct;
    frontend_pkg::reg_idx_t rs;
    frontend_pkg::reg_idx_t rt;
    frontend_pkg::reg_idx_t rd;

    logic is_rtype;
    logic is_jr;
    logic is_alu_imm;
    logic is_load;
    logic is_store;
    logic is_cond_br;
    logic is_j;
    logic is_jal;

    assign op    = slot.inst[31:26];
    assign rs    = slot.inst[25:21];
    assign rt    = slot.inst[20:16];
    assign rd    = slot.inst[15:11];
    assign funct = slot.inst[5:0];

    assign is_rtype   = (op == frontend_pkg::OP_SPECIAL);
    assign is_jr      = is_rtype && (funct == frontend_pkg::FUNCT_JR);
    assign is_alu_imm = (op[5:3] == frontend_pkg::OP_IMM_GRP);
    assign is_load    = (op == frontend_pkg::OP_LW);
    assign is_store   = (op == frontend_pkg::OP_SW);
    assign is_cond_br = (op == frontend_pkg::OP_BEQ) || (op == frontend_pkg::OP_BNE);
    assign is_j       = (op == frontend_pkg::OP_J);
    assign is_jal     = (op == frontend_pkg::OP_JAL);

    // unused sources stay 0 so they never match a destination
    always_comb begin
        info = '0;
        if (slot.valid) begin
            if (is_rtype) begin
                info.writes_reg = !is_jr;
                info.dst        = rd;
                info.src_a      = rs;
                info.src_b      = rt;
                info.is_branch  = is_jr;
            end else if (is_alu_imm) begin
                info.writes_reg = 1'b1;
                info.dst        = rt;
                info.src_a      = rs;
            end else if (is_load) begin
                info.writes_reg = 1'b1;
                info.dst        = rt;
                info.src_a      = rs; // base
                info.is_mem     = 1'b1;
            end else if (is_store) begin
                info.src_a  = rs;
                info.src_b  = rt; // store data
                info.is_mem = 1'b1;
            end else if (is_cond_br) begin
                info.src_a     = rs;
                info.src_b     = rt;
                info.is_branch = 1'b1;
            end else if (is_j) begin
                info.is_branch = 1'b1;
            end else if (is_jal) begin
                info.writes_reg = 1'b1;
                info.dst        = frontend_pkg::REG_RA;
                info.is_branch  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,

    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  frontend_pkg::fetch_pair_t fetch_pair,

    input  logic                      master_issue,
    input  logic                      slave_issue,
    input  logic                      master_is_branch,

    output frontend_pkg::slot_t       master_slot,
    output frontend_pkg::slot_t       slave_slot,
    output logic                      master_in_delay_slot
);

    frontend_pkg::fetch_pair_t pair_q;
    frontend_pkg::slot_t       left_q;   // slave left behind by a lone master
    logic                      dly_q;

    logic pair_done;
    logic left_fill;
    logic left_drain;
    logic left_next_valid;
    logic pair_load;

    // leftover first as it is older than the stored pair
    always_comb begin
        if (left_q.valid) begin
            master_slot = left_q;
            slave_slot  = '0;
        end else begin
            master_slot = '{valid: pair_q.ok1, addr: pair_q.addr1, inst: pair_q.inst1};
            slave_slot  = '{valid: pair_q.ok2, addr: pair_q.addr2, inst: pair_q.inst2};
        end
    end

    // an orphan slave (ok2 without ok1) can never issue and is dropped
    assign pair_done = !pair_q.ok1 || (master_issue && !left_q.valid);

    assign left_fill  = !left_q.valid && master_issue && pair_q.ok2 && !slave_issue;
    assign left_drain = left_q.valid && master_issue;

    assign left_next_valid = left_fill || (left_q.valid && !left_drain);

    assign fetch_ready = pair_done && !left_next_valid;
    assign pair_load   = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pair_q.ok1 <= 1'b0;
            pair_q.ok2 <= 1'b0;
        end else if (pair_load) begin
            pair_q <= fetch_pair;
        end else if (pair_done) begin
            pair_q.ok1 <= 1'b0; // slave may live on in left_q
            pair_q.ok2 <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            left_q.valid <= 1'b0;
        end else if (left_fill) begin
            left_q <= slave_slot;
        end else if (left_drain) begin
            left_q.valid <= 1'b0;
        end
    end

    // branch issued alone puts the next master in its delay slot
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dly_q <= 1'b0;
        end else if (master_issue) begin
            dly_q <= master_is_branch && !slave_issue;
        end
    end

    assign master_in_delay_slot = dly_q;

    // full leftover implies the stored pair is spent and cannot refill it
    a_left_alone: assert property (@(posedge clk) disable iff (rst)
        left_q.valid |-> !pair_q.ok1 && !pair_q.ok2)
        else $error("stored pair waiting behind a full leftover slot");

    a_slave_needs_master: assert property (@(posedge clk) disable iff (rst)
        slave_issue |-> master_issue)
        else $error("slave issued without its master");

endmodule

`default_nettype wire

//--- rtl/issue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,

    input  frontend_pkg::slot_t     master_slot,
    input  frontend_pkg::slot_t     slave_slot,
    input  frontend_pkg::dec_info_t master_dec,
    input  frontend_pkg::dec_info_t slave_dec,

    output logic                    master_issue,
    output logic                    slave_issue,
    output frontend_pkg::count_t    master_count,
    output frontend_pkg::count_t    slave_count
);

    logic raw_hazard;
    logic mem_conflict;
    logic slave_ok;

    // slave reads what the master writes this cycle
    always_comb begin
        raw_hazard = 1'b0;
        if (master_dec.writes_reg && (master_dec.dst != frontend_pkg::REG_ZERO)) begin
            raw_hazard = (slave_dec.src_a == master_dec.dst) ||
                         (slave_dec.src_b == master_dec.dst);
        end
    end

    assign mem_conflict = master_dec.is_mem && slave_dec.is_mem; // one memory port

    assign slave_ok = slave_slot.valid && !slave_dec.is_branch && !mem_conflict &&
                      !raw_hazard;

    assign master_issue = master_slot.valid && !stall;
    assign slave_issue  = master_issue && slave_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            master_count <= '0;
        end else if (master_issue) begin
            master_count <= master_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slave_count <= '0;
        end else if (slave_issue) begin
            slave_count <= slave_count + 1'b1;
        end
    end

    // counters freeze across a stalled cycle
    a_stall_freezes: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(master_count) && $stable(slave_count))
        else $error("issue counted during stall");

endmodule

`default_nettype wire

//--- rtl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,

    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  frontend_pkg::fetch_pair_t fetch_pair,

    output logic                      issue_valid,
    output frontend_pkg::issue_t      issued,
    output frontend_pkg::count_t      master_count,
    output frontend_pkg::count_t      slave_count
);

    frontend_pkg::slot_t     master_slot;
    frontend_pkg::slot_t     slave_slot;
    frontend_pkg::dec_info_t master_dec;
    frontend_pkg::dec_info_t slave_dec;

    logic master_issue;
    logic slave_issue;
    logic in_delay_slot;

    fetch_buffer u_fetch_buffer (
        .clk                  (clk),
        .rst                  (rst),
        .flush                (flush),
        .fetch_valid          (fetch_valid),
        .fetch_ready          (fetch_ready),
        .fetch_pair           (fetch_pair),
        .master_issue         (master_issue),
        .slave_issue          (slave_issue),
        .master_is_branch     (master_dec.is_branch),
        .master_slot          (master_slot),
        .slave_slot           (slave_slot),
        .master_in_delay_slot (in_delay_slot)
    );

    inst_decoder u_dec_master (
        .slot (master_slot),
        .info (master_dec)
    );

    inst_decoder u_dec_slave (
        .slot (slave_slot),
        .info (slave_dec)
    );

    issue_arbiter u_issue_arbiter (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .master_slot  (master_slot),
        .slave_slot   (slave_slot),
        .master_dec   (master_dec),
        .slave_dec    (slave_dec),
        .master_issue (master_issue),
        .slave_issue  (slave_issue),
        .master_count (master_count),
        .slave_count  (slave_count)
    );

    // only what actually leaves this cycle
    assign issue_valid                 = master_issue;
    assign issued.master               = master_issue ? master_slot : '0;
    assign issued.slave                = slave_issue ? slave_slot : '0;
    assign issued.master_in_delay_slot = master_issue && in_delay_slot;

endmodule

`default_nettype wire

//--- verif/frontend_checks.svh
`ifndef FRONTEND_CHECKS_SVH
`define FRONTEND_CHECKS_SVH

task automatic check_slot(input string name, input frontend_pkg::slot_t got,
                          input frontend_pkg::slot_t exp);
    if (got !== exp) begin
        stop_run($sformatf("[ERROR] line %0d %s: got valid=%h addr=%h inst=%h, exp %h %h %h",
                           line_no, name, got.valid, got.addr, got.inst,
                           exp.valid, exp.addr, exp.inst));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_run($sformatf("[ERROR] line %0d %s: got %h, expected %h",
                           line_no, name, got, exp));
    end
endtask

task automatic check_count(input string name, input frontend_pkg::count_t got,
                           input frontend_pkg::count_t exp);
    if (got !== exp) begin
        stop_run($sformatf("[ERROR] line %0d %s: got %h, expected %h",
                           line_no, name, got, exp));
    end
endtask

// polls just after each edge, like the stimulus
task automatic wait_ready(input int limit);
    int cycles;
    cycles = 0;
    while (fetch_ready !== 1'b1) begin
        if (cycles >= limit) begin
            stop_run($sformatf("fetch_ready still low after %0d cycles", limit));
        end
        @(posedge clk);
        #1;
        cycles++;
    end
endtask

`endif

//--- verif/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    logic                      clk;
    logic                      rst;
    logic                      flush;
    logic                      stall;
    logic                      fetch_valid;
    logic                      fetch_ready;
    frontend_pkg::fetch_pair_t fetch_pair;
    logic                      issue_valid;
    frontend_pkg::issue_t      issued;
    frontend_pkg::count_t      master_count;
    frontend_pkg::count_t      slave_count;

    integer fd;
    int     line_no;
    string  text;

    frontend_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stall        (stall),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_pair   (fetch_pair),
        .issue_valid  (issue_valid),
        .issued       (issued),
        .master_count (master_count),
        .slave_count  (slave_count)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    `include "frontend_checks.svh"

    function automatic bit is_data_line(input string s);
        if (s.len() == 0) begin
            return 1'b0;
        end
        return !(s.getc(0) == "#" || s.getc(0) == "\n");
    endfunction

    // one trace line is one clock cycle
    task automatic apply_and_check(input string s);
        logic [31:0]         col [20];
        int                  n;
        frontend_pkg::slot_t exp_master;
        frontend_pkg::slot_t exp_slave;
        n = $sscanf(s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                    col[15], col[16], col[17], col[18], col[19]);
        if (n != 20) begin
            stop_run($sformatf("trace line %0d has %0d fields instead of 20", line_no, n));
        end
        @(posedge clk);
        #1;
        fetch_valid      = col[0][0];
        fetch_pair.ok1   = col[1][0];
        fetch_pair.addr1 = col[2];
        fetch_pair.inst1 = col[3];
        fetch_pair.ok2   = col[4][0];
        fetch_pair.addr2 = col[5];
        fetch_pair.inst2 = col[6];
        stall            = col[7][0];
        flush            = col[8][0];
        exp_master.valid = col[11][0];
        exp_master.addr  = col[12];
        exp_master.inst  = col[13];
        exp_slave.valid  = col[14][0];
        exp_slave.addr   = col[15];
        exp_slave.inst   = col[16];
        #5; // settled, 2 ns before the next edge
        check_flag("fetch_ready", fetch_ready, col[9][0]);
        check_flag("issue_valid", issue_valid, col[10][0]);
        check_slot("issued.master", issued.master, exp_master);
        check_slot("issued.slave", issued.slave, exp_slave);
        check_flag("master_in_delay_slot", issued.master_in_delay_slot, col[17][0]);
        check_count("master_count", master_count, col[18]);
        check_count("slave_count", slave_count, col[19]);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        stall       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pair  = '0;
        line_no     = 0;

        fd = $fopen("verif/frontend_trace.txt", "r");
        if (fd == 0) begin
            stop_run("could not open verif/frontend_trace.txt");
        end else begin
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            wait_ready(20);
            while ($fgets(text, fd) != 0) begin
                line_no++;
                if (is_data_line(text)) begin
                    apply_and_check(text);
                end
            end
            $fclose(fd);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- frontend.f
+incdir+verif
rtl/frontend_pkg.sv
rtl/inst_decoder.sv
rtl/fetch_buffer.sv
rtl/issue_arbiter.sv
rtl/frontend_top.sv
verif/frontend_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = frontend_tb
FILELIST  = frontend.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero when the testbench stops on $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/frontend_trace.txt
# in:  fetch_valid ok1 addr1 inst1 ok2 addr2 inst2 stall flush
# exp: fetch_ready issue_valid m_valid m_addr m_inst s_valid s_addr s_inst delay_slot m_cnt s_cnt
# independent pairs dual issue
1 1 100 00221820 1 104 00853020 0 0  1 0 0 0 0 0 0 0 0 0 0
1 1 108 01ae6020 1 10c 02117820 0 0  1 1 1 100 00221820 1 104 00853020 0 0 0
1 1 110 00221820 1 114 20670001 0 0  1 1 1 108 01ae6020 1 10c 02117820 0 1 1
# raw hazard, slave waits as leftover
1 1 118 8d280000 1 11c ad6a0004 0 0  0 1 1 110 00221820 0 0 0 0 2 2
1 1 118 8d280000 1 11c ad6a0004 0 0  1 1 1 114 20670001 0 0 0 0 3 2
# two memory ops
1 1 120 00221820 1 124 10220004 0 0  0 1 1 118 8d280000 0 0 0 0 4 2
1 1 120 00221820 1 124 10220004 0 0  1 1 1 11c ad6a0004 0 0 0 0 5 2
# branch slave held, then issues alone
1 1 128 01ae6020 1 12c 02117820 0 0  0 1 1 120 00221820 0 0 0 0 6 2
1 1 128 01ae6020 1 12c 02117820 0 0  1 1 1 124 10220004 0 0 0 0 7 2
# delay slot pair
1 1 130 10220004 1 134 00853020 0 0  1 1 1 128 01ae6020 1 12c 02117820 1 8 2
# stall with a branch pair presented
1 1 138 00221820 1 13c 00853020 1 0  0 0 0 0 0 0 0 0 0 9 3
1 1 138 00221820 1 13c 00853020 1 0  0 0 0 0 0 0 0 0 0 9 3
1 1 138 00221820 1 13c 00853020 0 0  1 1 1 130 10220004 1 134 00853020 0 9 3
0 0 0 0 0 0 0 0 0  1 1 1 138 00221820 1 13c 00853020 0 a 4
# half valid pairs
1 1 140 01ae6020 0 0 0 0 0  1 0 0 0 0 0 0 0 0 b 5
1 0 0 0 1 14c 02117820 0 0  1 1 1 140 01ae6020 0 0 0 0 b 5
1 1 150 00221820 1 154 20670001 0 0  1 0 0 0 0 0 0 0 0 c 5
0 0 0 0 0 0 0 0 0  0 1 1 150 00221820 0 0 0 0 c 5
# flush with a leftover, then with a stored pair
0 0 0 0 0 0 0 1 1  0 0 0 0 0 0 0 0 0 d 5
1 1 160 01ae6020 1 164 02117820 0 0  1 0 0 0 0 0 0 0 0 d 5
0 0 0 0 0 0 0 1 1  0 0 0 0 0 0 0 0 0 d 5
0 0 0 0 0 0 0 1 0  1 0 0 0 0 0 0 0 0 d 5
# issue resumes after flush
1 1 170 00853020 1 174 01ae6020 0 0  1 0 0 0 0 0 0 0 0 d 5
0 0 0 0 0 0 0 0 0  1 1 1 170 00853020 1 174 01ae6020 0 d 5
0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 e 6
